/* src/ext_mem_pkg.sv */
// External memory subsystem shared definitions
// Bus structs, memcopy register map, memory and queue sizes
package ext_mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
    logic  ready;
  } reg_rsp_t;

  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_rsp_t;

  // Arbiter masters, index order is priority order
  typedef logic [1:0] mst_idx_t;
  localparam mst_idx_t MST_HOST = 2'd0;
  localparam mst_idx_t MST_DMA_RD = 2'd1;
  localparam mst_idx_t MST_DMA_WR = 2'd2;
  localparam int unsigned NUM_MST = 3;

  localparam int unsigned MEM_WORDS = 128;
  typedef logic [6:0] word_idx_t;
  localparam int unsigned SLOW_GNT_WAIT = 2;
  typedef logic [$clog2(SLOW_GNT_WAIT + 1)-1:0] wait_cnt_t;

  localparam int unsigned FIFO_DEPTH = 2;
  typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH + 1)-1:0] fifo_cnt_t;
  localparam int unsigned ORDER_DEPTH = 4;
  typedef logic [$clog2(ORDER_DEPTH)-1:0] ord_ptr_t;
  typedef logic [$clog2(ORDER_DEPTH + 1)-1:0] ord_cnt_t;

  // Memcopy window of 16 bytes
  localparam addr_t MEMCOPY_BASE = 32'h0000_0100;
  localparam addr_t MEMCOPY_MASK = 32'hFFFF_FFF0;
  localparam logic [3:0] REG_SRC = 4'h0;
  localparam logic [3:0] REG_DST = 4'h4;
  localparam logic [3:0] REG_LEN = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hC;

  typedef enum logic [2:0] {
    IDLE,
    READ_REQ,
    READ_WAIT,
    WRITE_REQ,
    WRITE_WAIT
  } dma_state_e;

  // Byte-enable merge of a new word into an old one
  function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* src/slow_memory.sv */
// Slow OBI memory of 128 words
// Grants after a fixed wait, byte-writable, response one cycle after grant
module slow_memory (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ext_mem_pkg::obi_req_t req_i,
  output ext_mem_pkg::obi_rsp_t rsp_o
);
  import ext_mem_pkg::*;

  data_t mem_q [MEM_WORDS];
  wait_cnt_t wait_q;
  word_idx_t word_idx;
  logic gnt;
  logic rvalid_q;
  data_t rdata_q;

  assign word_idx = req_i.addr[8:2];
  assign gnt = req_i.req && (wait_q == wait_cnt_t'(SLOW_GNT_WAIT));

  assign rsp_o.gnt = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata = rdata_q;

  // Wait counter restarts for each new request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (!req_i.req || gnt) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + wait_cnt_t'(1);
      end
    end
  end

  // Writes also return the old word
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= mem_q[word_idx];
      if (req_i.we) begin
        mem_q[word_idx] <= apply_strb(mem_q[word_idx], req_i.wdata, req_i.be);
      end
    end
  end

endmodule

/* src/obi_fifo.sv */
// OBI request FIFO
// Queues granted requests and replays the oldest until the consumer takes it
module obi_fifo (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ext_mem_pkg::obi_req_t producer_req_i,
  output ext_mem_pkg::obi_rsp_t producer_rsp_o,
  output ext_mem_pkg::obi_req_t consumer_req_o,
  input  ext_mem_pkg::obi_rsp_t consumer_rsp_i
);
  import ext_mem_pkg::*;

  obi_req_t fifo_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic full;
  logic push;
  logic pop;

  assign full = (count_q == fifo_cnt_t'(FIFO_DEPTH));
  assign push = producer_req_i.req && producer_rsp_o.gnt;
  assign pop = consumer_req_o.req && consumer_rsp_i.gnt;

  // Responses go straight back
  always_comb begin
    producer_rsp_o = consumer_rsp_i;
    producer_rsp_o.gnt = producer_req_i.req && !full;
  end

  always_comb begin
    consumer_req_o = fifo_q[rd_ptr_q];
    consumer_req_o.req = (count_q != '0);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
      end
      if (push && !pop) begin
        count_q <= count_q + fifo_cnt_t'(1);
      end else if (!push && pop) begin
        count_q <= count_q - fifo_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= producer_req_i;
    end
  end

  // A push into a full queue would raise the count past the depth
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= fifo_cnt_t'(FIFO_DEPTH));

endmodule

/* src/obi_arbiter.sv */
// Three-to-one OBI arbiter
// Fixed priority grant, responses routed back through an in-order queue
module obi_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ext_mem_pkg::obi_req_t host_req_i,
  output ext_mem_pkg::obi_rsp_t host_rsp_o,
  input  ext_mem_pkg::obi_req_t rd_req_i,
  output ext_mem_pkg::obi_rsp_t rd_rsp_o,
  input  ext_mem_pkg::obi_req_t wr_req_i,
  output ext_mem_pkg::obi_rsp_t wr_rsp_o,
  output ext_mem_pkg::obi_req_t mem_req_o,
  input  ext_mem_pkg::obi_rsp_t mem_rsp_i
);
  import ext_mem_pkg::*;

  obi_req_t mst_req [NUM_MST];
  obi_rsp_t mst_rsp [NUM_MST];
  mst_idx_t sel;
  logic any_req;
  logic grant;
  mst_idx_t ord_q [ORDER_DEPTH];
  ord_ptr_t ord_wr_q;
  ord_ptr_t ord_rd_q;
  ord_cnt_t ord_cnt_q;
  logic ord_full;
  mst_idx_t ord_head;

  assign mst_req[MST_HOST] = host_req_i;
  assign mst_req[MST_DMA_RD] = rd_req_i;
  assign mst_req[MST_DMA_WR] = wr_req_i;
  assign host_rsp_o = mst_rsp[MST_HOST];
  assign rd_rsp_o = mst_rsp[MST_DMA_RD];
  assign wr_rsp_o = mst_rsp[MST_DMA_WR];

  assign ord_full = (ord_cnt_q == ord_cnt_t'(ORDER_DEPTH));
  assign ord_head = ord_q[ord_rd_q];
  assign grant = mem_req_o.req && mem_rsp_i.gnt;

  // Lowest index wins
  always_comb begin
    sel = MST_HOST;
    any_req = 1'b0;
    for (int m = NUM_MST - 1; m >= 0; m--) begin
      if (mst_req[m].req) begin
        sel = mst_idx_t'(m);
        any_req = 1'b1;
      end
    end
  end

  always_comb begin
    mem_req_o = mst_req[sel];
    mem_req_o.req = any_req && !ord_full;
  end

  always_comb begin
    for (int m = 0; m < NUM_MST; m++) begin
      mst_rsp[m].gnt = grant && (sel == mst_idx_t'(m));
      mst_rsp[m].rvalid = mem_rsp_i.rvalid && (ord_head == mst_idx_t'(m));
      mst_rsp[m].rdata = (ord_head == mst_idx_t'(m)) ? mem_rsp_i.rdata : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ord_wr_q <= '0;
      ord_rd_q <= '0;
      ord_cnt_q <= '0;
    end else begin
      if (grant) begin
        ord_wr_q <= ord_wr_q + ord_ptr_t'(1);
      end
      if (mem_rsp_i.rvalid) begin
        ord_rd_q <= ord_rd_q + ord_ptr_t'(1);
      end
      if (grant && !mem_rsp_i.rvalid) begin
        ord_cnt_q <= ord_cnt_q + ord_cnt_t'(1);
      end else if (!grant && mem_rsp_i.rvalid) begin
        ord_cnt_q <= ord_cnt_q - ord_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      ord_q[ord_wr_q] <= sel;
    end
  end

  // Every response downstream belongs to an earlier grant
  a_rvalid_tracked: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rsp_i.rvalid |-> ord_cnt_q != '0);

endmodule

/* src/memcopy_dma.sv */
// Memcopy DMA engine
// Register bus slave plus OBI read and write masters, moves one word at a time
module memcopy_dma (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ext_mem_pkg::reg_req_t reg_req_i,
  output ext_mem_pkg::reg_rsp_t reg_rsp_o,
  output ext_mem_pkg::obi_req_t rd_req_o,
  input  ext_mem_pkg::obi_rsp_t rd_rsp_i,
  output ext_mem_pkg::obi_req_t wr_req_o,
  input  ext_mem_pkg::obi_rsp_t wr_rsp_i,
  output logic                  done_intr_o
);
  import ext_mem_pkg::*;

  dma_state_e state_q;
  addr_t src_q;
  addr_t dst_q;
  data_t len_q;
  data_t remain_q;
  addr_t off_q;
  data_t data_q;
  logic done_q;
  logic busy;
  logic in_win;
  logic [3:0] reg_off;
  logic reg_wr;
  logic status_rd;
  data_t reg_wval;

  assign busy = (state_q != IDLE);
  assign in_win = ((reg_req_i.addr & MEMCOPY_MASK) == MEMCOPY_BASE);
  assign reg_off = reg_req_i.addr[3:0];
  assign done_intr_o = done_q;

  // Register access completes in the cycle it is presented
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_off)
      REG_SRC: reg_rsp_o.rdata = src_q;
      REG_DST: reg_rsp_o.rdata = dst_q;
      REG_LEN: reg_rsp_o.rdata = len_q;
      REG_STATUS: reg_rsp_o.rdata = {30'd0, done_q, busy};
      default: reg_rsp_o.error = reg_req_i.valid;
    endcase
    // STATUS is read-only, config is locked while busy
    if (!in_win || (reg_req_i.write && (busy || reg_off == REG_STATUS))) begin
      reg_rsp_o.error = reg_req_i.valid;
    end
    reg_wr = reg_req_i.valid && reg_req_i.write && !reg_rsp_o.error;
    status_rd = reg_req_i.valid && !reg_req_i.write && in_win && (reg_off == REG_STATUS);
    reg_wval = apply_strb(reg_rsp_o.rdata, reg_req_i.wdata, reg_req_i.wstrb);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
      remain_q <= '0;
      off_q <= '0;
      done_q <= 1'b0;
    end else begin
      if (status_rd) begin
        done_q <= 1'b0;
      end
      if (reg_wr) begin
        case (reg_off)
          REG_SRC: src_q <= reg_wval;
          REG_DST: dst_q <= reg_wval;
          REG_LEN: begin
            len_q <= reg_wval;
            remain_q <= reg_wval;
            off_q <= '0;
            // Zero length finishes at once
            done_q <= (reg_wval == '0);
            if (reg_wval != '0) begin
              state_q <= READ_REQ;
            end
          end
          default: ;
        endcase
      end
      case (state_q)
        READ_REQ: if (rd_rsp_i.gnt) state_q <= READ_WAIT;
        READ_WAIT: if (rd_rsp_i.rvalid) state_q <= WRITE_REQ;
        WRITE_REQ: if (wr_rsp_i.gnt) state_q <= WRITE_WAIT;
        WRITE_WAIT: begin
          if (wr_rsp_i.rvalid) begin
            off_q <= off_q + 32'd4;
            remain_q <= remain_q - 32'd1;
            if (remain_q == 32'd1) begin
              state_q <= IDLE;
              done_q <= 1'b1;
            end else begin
              state_q <= READ_REQ;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // Word in transit between read and write
  always_ff @(posedge clk_i) begin
    if (state_q == READ_WAIT && rd_rsp_i.rvalid) begin
      data_q <= rd_rsp_i.rdata;
    end
  end

  always_comb begin
    rd_req_o = '0;
    rd_req_o.req = (state_q == READ_REQ);
    rd_req_o.be = '1;
    rd_req_o.addr = src_q + off_q;
    wr_req_o.req = (state_q == WRITE_REQ);
    wr_req_o.we = 1'b1;
    wr_req_o.be = '1;
    wr_req_o.addr = dst_q + off_q;
    wr_req_o.wdata = data_q;
  end

  a_rd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_req_o.req && !rd_rsp_i.gnt |=> $stable(rd_req_o));
  a_wr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_req_o.req && !wr_rsp_i.gnt |=> $stable(wr_req_o));
  // Arbiter must never route a response to an idle engine
  a_idle_no_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q == IDLE |-> !(rd_rsp_i.rvalid || wr_rsp_i.rvalid));

endmodule

/* src/ext_mem_top.sv */
// External memory subsystem top
// Host port and memcopy DMA share the slow memory through arbiter and FIFO
module ext_mem_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ext_mem_pkg::reg_req_t reg_req_i,
  output ext_mem_pkg::reg_rsp_t reg_rsp_o,
  input  ext_mem_pkg::obi_req_t obi_req_i,
  output ext_mem_pkg::obi_rsp_t obi_rsp_o,
  output logic                  memcopy_intr_o
);
  import ext_mem_pkg::*;

  obi_req_t dma_rd_req;
  obi_rsp_t dma_rd_rsp;
  obi_req_t dma_wr_req;
  obi_rsp_t dma_wr_rsp;
  obi_req_t fifo_in_req;
  obi_rsp_t fifo_in_rsp;
  obi_req_t mem_req;
  obi_rsp_t mem_rsp;

  memcopy_dma memcopy_dma_i (
    .clk_i,
    .rst_i,
    .reg_req_i,
    .reg_rsp_o,
    .rd_req_o   (dma_rd_req),
    .rd_rsp_i   (dma_rd_rsp),
    .wr_req_o   (dma_wr_req),
    .wr_rsp_i   (dma_wr_rsp),
    .done_intr_o(memcopy_intr_o)
  );

  obi_arbiter obi_arbiter_i (
    .clk_i,
    .rst_i,
    .host_req_i(obi_req_i),
    .host_rsp_o(obi_rsp_o),
    .rd_req_i  (dma_rd_req),
    .rd_rsp_o  (dma_rd_rsp),
    .wr_req_i  (dma_wr_req),
    .wr_rsp_o  (dma_wr_rsp),
    .mem_req_o (fifo_in_req),
    .mem_rsp_i (fifo_in_rsp)
  );

  // Extra latency in front of the memory
  obi_fifo obi_fifo_i (
    .clk_i,
    .rst_i,
    .producer_req_i(fifo_in_req),
    .producer_rsp_o(fifo_in_rsp),
    .consumer_req_o(mem_req),
    .consumer_rsp_i(mem_rsp)
  );

  slow_memory slow_memory_i (
    .clk_i,
    .rst_i,
    .req_i(mem_req),
    .rsp_o(mem_rsp)
  );

endmodule

/* dv/tb_ext_mem.sv */
// Testbench for the external memory subsystem
// Host OBI bursts and memcopy cases checked against a word model
module tb_ext_mem;
  import ext_mem_pkg::*;

  localparam int NUM_CASES = 5;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int POLL_LIMIT = 500;
  localparam int MIXED_WORDS = 12;

  logic clk_i = 1'b0;
  logic rst_i;
  reg_req_t reg_req_i;
  reg_rsp_t reg_rsp_o;
  obi_req_t obi_req_i;
  obi_rsp_t obi_rsp_o;
  logic memcopy_intr_o;

  logic [31:0] lfsr_q = 32'h5f0c_0c57;
  data_t model [MEM_WORDS];
  obi_req_t burst_req [$];
  data_t burst_exp [$];
  bit burst_chk [$];
  data_t reg_rdata;
  logic reg_error;
  logic reg_intr;

  // Memcopy cases, word indices into the memory
  string case_name [NUM_CASES] = '{"one_word", "block8", "len_zero", "busy_probe", "tail16"};
  int case_src [NUM_CASES] = '{3, 8, 20, 16, 0};
  int case_dst [NUM_CASES] = '{40, 64, 90, 100, 112};
  int case_len [NUM_CASES] = '{1, 8, 0, 6, 16};
  bit case_busy [NUM_CASES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  ext_mem_top ext_mem_top_i (
    .clk_i,
    .rst_i,
    .reg_req_i,
    .reg_rsp_o,
    .obi_req_i,
    .obi_rsp_o,
    .memcopy_intr_o
  );

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic data_t rand_bits(int unsigned n);
    data_t val;
    logic fb;
    val = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
    data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic check_eq(input string name, input data_t exp_val, input data_t act_val);
    assert (act_val === exp_val) else begin
      $display("** Error %s: expected %08h, actual %08h", name, exp_val, act_val);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic reg_access(input logic wr, input addr_t addr, input data_t wdata);
    int cycles;
    @(negedge clk_i);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = wr;
    reg_req_i.addr = addr;
    reg_req_i.wdata = wdata;
    reg_req_i.wstrb = '1;
    cycles = 0;
    #1;
    while (!reg_rsp_o.ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) timed_out("register ready");
      @(negedge clk_i);
      #1;
    end
    reg_rdata = reg_rsp_o.rdata;
    reg_error = reg_rsp_o.error;
    reg_intr = memcopy_intr_o;
    @(negedge clk_i);
    reg_req_i = '0;
  endtask

  // Expected response is the word before the access, writes update the model
  task automatic queue_access(input logic we, input int idx, input strb_t be,
                              input data_t wdata, input bit chk);
    obi_req_t r;
    r = '0;
    r.req = 1'b1;
    r.we = we;
    r.be = be;
    r.addr = addr_t'(idx * 4);
    r.wdata = wdata;
    burst_req.push_back(r);
    burst_exp.push_back(model[idx]);
    burst_chk.push_back(chk);
    if (we) model[idx] = merge_bytes(model[idx], wdata, be);
  endtask

  // Issues queued requests back to back while collecting responses
  task automatic run_burst(input string name);
    int total;
    int issued;
    int received;
    int idle;
    total = burst_req.size();
    issued = 0;
    received = 0;
    idle = 0;
    while (received < total) begin
      @(negedge clk_i);
      if (issued < total) obi_req_i = burst_req[issued];
      else obi_req_i = '0;
      #1;
      if (obi_rsp_o.rvalid) begin
        if (burst_chk[received]) check_eq(name, burst_exp[received], obi_rsp_o.rdata);
        received++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT_CYCLES) timed_out("host rvalid");
      end
      if (obi_req_i.req && obi_rsp_o.gnt) issued++;
    end
    @(negedge clk_i);
    obi_req_i = '0;
    burst_req.delete();
    burst_exp.delete();
    burst_chk.delete();
  endtask

  task automatic run_case(input int c);
    string name;
    int src;
    int dst;
    int len;
    int polls;
    name = case_name[c];
    src = case_src[c];
    dst = case_dst[c];
    len = case_len[c];
    for (int i = 0; i < len; i++) begin
      queue_access(1'b1, src + i, 4'hF, rand_bits(32), 1'b1);
    end
    run_burst({name, "_fill"});
    reg_access(1'b1, {MEMCOPY_BASE[31:4], REG_SRC}, data_t'(src * 4));
    check_eq({name, "_src_err"}, 32'd0, {31'd0, reg_error});
    reg_access(1'b1, {MEMCOPY_BASE[31:4], REG_DST}, data_t'(dst * 4));
    check_eq({name, "_dst_err"}, 32'd0, {31'd0, reg_error});
    reg_access(1'b1, {MEMCOPY_BASE[31:4], REG_LEN}, data_t'(len));
    check_eq({name, "_len_err"}, 32'd0, {31'd0, reg_error});
    if (case_busy[c]) begin
      reg_access(1'b1, {MEMCOPY_BASE[31:4], REG_LEN}, data_t'(len + 2));
      check_eq({name, "_busy_err"}, 32'd1, {31'd0, reg_error});
    end
    polls = 0;
    do begin
      reg_access(1'b0, {MEMCOPY_BASE[31:4], REG_STATUS}, 32'd0);
      polls++;
      if (polls > POLL_LIMIT) timed_out("memcopy done");
    end while (!reg_rdata[1]);
    check_eq({name, "_status_done"}, 32'h2, reg_rdata);
    check_eq({name, "_intr_done"}, 32'd1, {31'd0, reg_intr});
    reg_access(1'b0, {MEMCOPY_BASE[31:4], REG_STATUS}, 32'd0);
    check_eq({name, "_status_clear"}, 32'd0, reg_rdata);
    check_eq({name, "_intr_clear"}, 32'd0, {31'd0, memcopy_intr_o});
    reg_access(1'b0, {MEMCOPY_BASE[31:4], REG_LEN}, 32'd0);
    check_eq({name, "_len_kept"}, data_t'(len), reg_rdata);
    // Forward word copy
    for (int i = 0; i < len; i++) begin
      model[dst + i] = model[src + i];
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      queue_access(1'b0, i, 4'hF, 32'd0, 1'b1);
    end
    run_burst({name, "_readback"});
  endtask

  initial begin
    rst_i = 1'b1;
    reg_req_i = '0;
    obi_req_i = '0;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;

    check_eq("reset_intr", 32'd0, {31'd0, memcopy_intr_o});
    reg_access(1'b0, {MEMCOPY_BASE[31:4], REG_STATUS}, 32'd0);
    check_eq("reset_status", 32'd0, reg_rdata);
    check_eq("reset_status_err", 32'd0, {31'd0, reg_error});

    // Memory has no reset value, fill it first
    for (int i = 0; i < MEM_WORDS; i++) begin
      queue_access(1'b1, i, 4'hF, rand_bits(32), 1'b0);
    end
    run_burst("host_fill");

    for (int i = 0; i < MIXED_WORDS; i++) begin
      queue_access(1'b1, 48 + i, strb_t'(rand_bits(4)), rand_bits(32), 1'b1);
      queue_access(1'b0, 48 + i, 4'hF, 32'd0, 1'b1);
    end
    run_burst("host_mixed");

    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end

    reg_access(1'b0, 32'h0000_0200, 32'd0);
    check_eq("window_read_err", 32'd1, {31'd0, reg_error});
    reg_access(1'b1, 32'h0000_0110, 32'h0000_0004);
    check_eq("window_write_err", 32'd1, {31'd0, reg_error});

    $display("TEST OK");
    $finish;
  end

endmodule

/* build.f */
src/ext_mem_pkg.sv
src/slow_memory.sv
src/obi_fifo.sv
src/obi_arbiter.sv
src/memcopy_dma.sv
src/ext_mem_top.sv
dv/tb_ext_mem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the external memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_ext_mem -o tb_ext_mem

./obj_dir/tb_ext_mem
